// ==== hdl/i2_pkg.sv ====
// Shared widths, opcodes, ALU operation codes and stage payloads of the second issue lane

package i2_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  parameter int XLEN       = 32; // RV32 datapath
  parameter int REG_ADDR_W = 5;  // x0..x31

  //////////////////////////////
  // Major opcodes accepted by the lane
  //////////////////////////////

  parameter logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU

  // ALU operations, one per supported RV32I integer instruction pair
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // Chosen forwarding source of one operand
  typedef enum logic [1:0] {
    SRC_EX  = 2'd0, // Own EX result
    SRC_XFW = 2'd1, // Primary lane cross-forward
    SRC_WB  = 2'd2, // Own WB entry
    SRC_RF  = 2'd3  // Register file, also x0
  } src_sel_e;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////

  // IF/ID payload, 64 bits
  typedef struct packed {
    logic [31:0]     instr; // Raw instruction word
    logic [XLEN-1:0] pc;    // Its address, kept alongside for tracking
  } fetch_t;

  // ID/EX payload, 74 bits
  typedef struct packed {
    alu_op_e               alu_op; // 4
    logic [XLEN-1:0]       op_a;   // Forwarded rs1
    logic [XLEN-1:0]       op_b;   // Forwarded rs2 or immediate
    logic [REG_ADDR_W-1:0] rd;     // Destination
    logic                  we;     // Low for x0 destinations
  } ex_req_t;

endpackage

// ==== hdl/i2_bypass_if.sv ====
// Forwarding bus from the lane's EX/WB stages and the primary lane to the operand-bypass units
`timescale 1ns/10ps

interface i2_bypass_if;

  // Own EX stage, ALU output of the instruction in ID/EX
  logic                          ex_we;
  logic [i2_pkg::REG_ADDR_W-1:0] ex_waddr;
  logic [i2_pkg::XLEN-1:0]       ex_wdata;

  // Own WB stage, equals the register-file write port
  logic                          wb_we;
  logic [i2_pkg::REG_ADDR_W-1:0] wb_waddr;
  logic [i2_pkg::XLEN-1:0]       wb_wdata;

  // Primary lane cross-forward, driven from top-level ports
  logic                          xfw_we;
  logic [i2_pkg::REG_ADDR_W-1:0] xfw_waddr;
  logic [i2_pkg::XLEN-1:0]       xfw_wdata;

  // Producer side inside the lane
  modport ex_src (
    output ex_we, ex_waddr, ex_wdata,
    output wb_we, wb_waddr, wb_wdata
  );

  // Consumer side, one per source operand
  modport sink (
    input ex_we,  ex_waddr,  ex_wdata,
    input wb_we,  wb_waddr,  wb_wdata,
    input xfw_we, xfw_waddr, xfw_wdata
  );

endinterface

// ==== hdl/i2_stage_reg.sv ====
// Valid/payload pipeline register of any payload type, holds on stall and empties on kill
`timescale 1ns/10ps

module i2_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,   // Upstream offers an item
  input  payload_t data_i,
  input  logic     advance_i, // Pipeline moves this cycle
  input  logic     kill_i,    // Primary branch, drop the held item
  output logic     taken_o,   // Offered item accepted at this edge
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accepted only when moving and not being flushed
  assign taken_o = valid_i && advance_i && !kill_i;

  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i || kill_i) begin
      valid_q <= 1'b0;
    end else if (advance_i) begin
      valid_q <= valid_i;                    // Bubble when nothing offered
    end
  end

  // Payload follows the accepted item only
  always_ff @(posedge clk_i) begin
    if (taken_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== hdl/i2_decoder.sv ====
// Combinational RV32 decoder for the OP and OP-IMM groups, flags every other word
`timescale 1ns/10ps

module i2_decoder (
  input  logic                                valid_i,       // IF/ID holds a word
  input  i2_pkg::fetch_t                      fetch_i,
  output logic [1:0][i2_pkg::REG_ADDR_W-1:0]  rs_addr_o,     // rs1, rs2
  output i2_pkg::alu_op_e                     alu_op_o,
  output logic [i2_pkg::REG_ADDR_W-1:0]       rd_o,
  output logic                                we_o,          // Never set for x0
  output logic [i2_pkg::XLEN-1:0]             imm_o,
  output logic                                use_imm_o,     // Operand B from imm_o
  output logic                                issue_valid_o, // Goes on to ID/EX
  output logic                                unsupported_o  // Dropped, primary handles it
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_op;
  logic       is_op_imm;
  logic       f7_zero;   // funct7 all zero
  logic       f7_alt;    // SUB/SRA marker
  logic       is_shift;
  logic       legal;

  assign opcode    = fetch_i.instr[6:0];
  assign funct3    = fetch_i.instr[14:12];
  assign funct7    = fetch_i.instr[31:25];
  assign is_op     = opcode == i2_pkg::OPC_OP;
  assign is_op_imm = opcode == i2_pkg::OPC_OP_IMM;
  assign f7_zero   = funct7 == 7'b0000000;
  assign f7_alt    = funct7 == 7'b0100000;
  assign is_shift  = funct3[1:0] == 2'b01; // SLL(I), SRL(I), SRA(I)

  //////////////////////////////
  // Operation and legality
  //////////////////////////////

  always_comb begin
    alu_op_o = i2_pkg::ALU_ADD;
    legal    = 1'b0;
    case (funct3)
      3'b000: begin
        // ADDI has no funct7, immediate bits live there
        alu_op_o = (is_op && f7_alt) ? i2_pkg::ALU_SUB : i2_pkg::ALU_ADD;
        legal    = is_op_imm || f7_zero || f7_alt;
      end
      3'b001: begin
        alu_op_o = i2_pkg::ALU_SLL;
        legal    = f7_zero;                  // SLLI too
      end
      3'b010: begin
        alu_op_o = i2_pkg::ALU_SLT;
        legal    = is_op_imm || f7_zero;
      end
      3'b011: begin
        alu_op_o = i2_pkg::ALU_SLTU;
        legal    = is_op_imm || f7_zero;
      end
      3'b100: begin
        alu_op_o = i2_pkg::ALU_XOR;
        legal    = is_op_imm || f7_zero;
      end
      3'b101: begin
        alu_op_o = f7_alt ? i2_pkg::ALU_SRA : i2_pkg::ALU_SRL;
        legal    = f7_zero || f7_alt;        // Same rule for SRLI/SRAI
      end
      3'b110: begin
        alu_op_o = i2_pkg::ALU_OR;
        legal    = is_op_imm || f7_zero;
      end
      default: begin
        alu_op_o = i2_pkg::ALU_AND;
        legal    = is_op_imm || f7_zero;
      end
    endcase
    legal = legal && (is_op || is_op_imm);   // Loads, stores, branches etc. dropped
  end

  //////////////////////////////
  // Registers and immediate
  //////////////////////////////

  assign rs_addr_o[0] = fetch_i.instr[19:15];
  assign rs_addr_o[1] = is_op ? fetch_i.instr[24:20] : '0; // x0 when imm form
  assign rd_o         = fetch_i.instr[11:7];
  assign we_o         = legal && (rd_o != '0);

  // Shift amount zero-extended, otherwise sign-extended I-type
  assign imm_o = is_shift ? {{(i2_pkg::XLEN-5){1'b0}}, fetch_i.instr[24:20]}
                          : {{(i2_pkg::XLEN-12){fetch_i.instr[31]}}, fetch_i.instr[31:20]};
  assign use_imm_o = is_op_imm;

  assign issue_valid_o = valid_i && legal;
  assign unsupported_o = valid_i && !legal;

endmodule

// ==== hdl/i2_operand_bypass.sv ====
// Picks one source operand from EX, primary cross-forward, WB or register file, x0 reads zero
`timescale 1ns/10ps

module i2_operand_bypass (
  input  logic [i2_pkg::REG_ADDR_W-1:0] rs_addr_i,
  input  logic [i2_pkg::XLEN-1:0]       rf_rdata_i, // Combinational RF read
  i2_bypass_if.sink                     fwd,
  output logic [i2_pkg::XLEN-1:0]       operand_o,
  output i2_pkg::src_sel_e              src_o       // Winning source
);

  logic hit_ex;
  logic hit_xfw;
  logic hit_wb;

  // Address matches, x0 excluded up front
  assign hit_ex  = fwd.ex_we  && (fwd.ex_waddr  == rs_addr_i);
  assign hit_xfw = fwd.xfw_we && (fwd.xfw_waddr == rs_addr_i);
  assign hit_wb  = fwd.wb_we  && (fwd.wb_waddr  == rs_addr_i);

  // Youngest producer wins
  always_comb begin
    if (rs_addr_i == '0) begin
      operand_o = '0;                        // Hardwired zero
      src_o     = i2_pkg::SRC_RF;
    end else if (hit_ex) begin
      operand_o = fwd.ex_wdata;
      src_o     = i2_pkg::SRC_EX;
    end else if (hit_xfw) begin
      operand_o = fwd.xfw_wdata;             // Primary lane, same age as our EX
      src_o     = i2_pkg::SRC_XFW;
    end else if (hit_wb) begin
      operand_o = fwd.wb_wdata;
      src_o     = i2_pkg::SRC_WB;
    end else begin
      operand_o = rf_rdata_i;
      src_o     = i2_pkg::SRC_RF;
    end
  end

endmodule

// ==== hdl/i2_ex_stage.sv ====
// Execute stage of the second lane, ALU plus EX/WB register feeding the register-file write port
`timescale 1ns/10ps

module i2_ex_stage (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_valid_i, // ID/EX valid
  input  i2_pkg::ex_req_t               req_i,
  input  logic                          pi_ready_i,  // Combined primary ready level
  input  logic                          pi_kill_i,   // Primary branch taken
  i2_bypass_if.ex_src                   fwd,
  output logic                          rf_we_o,
  output logic [i2_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [i2_pkg::XLEN-1:0]       rf_wdata_o
);

  logic [i2_pkg::XLEN-1:0]       adder_b;
  logic [i2_pkg::XLEN-1:0]       sum;
  logic                          is_sub;
  logic [4:0]                    shamt;
  logic [i2_pkg::XLEN-1:0]       alu_result;
  logic                          ex_go;      // EX item moves into WB
  logic                          wb_we_q;
  logic [i2_pkg::REG_ADDR_W-1:0] wb_waddr_q;
  logic [i2_pkg::XLEN-1:0]       wb_wdata_q;

  //////////////////////////////
  // ALU
  //////////////////////////////

  // One adder for ADD and SUB
  assign is_sub  = req_i.alu_op == i2_pkg::ALU_SUB;
  assign adder_b = is_sub ? ~req_i.op_b : req_i.op_b;
  assign sum     = req_i.op_a + adder_b + {{(i2_pkg::XLEN-1){1'b0}}, is_sub};
  assign shamt   = req_i.op_b[4:0];           // Low five bits only

  always_comb begin
    case (req_i.alu_op)
      i2_pkg::ALU_ADD,
      i2_pkg::ALU_SUB:  alu_result = sum;
      i2_pkg::ALU_AND:  alu_result = req_i.op_a & req_i.op_b;
      i2_pkg::ALU_OR:   alu_result = req_i.op_a | req_i.op_b;
      i2_pkg::ALU_XOR:  alu_result = req_i.op_a ^ req_i.op_b;
      i2_pkg::ALU_SLL:  alu_result = req_i.op_a << shamt;
      i2_pkg::ALU_SRL:  alu_result = req_i.op_a >> shamt;
      i2_pkg::ALU_SRA:  alu_result = $signed(req_i.op_a) >>> shamt;
      i2_pkg::ALU_SLT:  alu_result = {{(i2_pkg::XLEN-1){1'b0}},
                                      $signed(req_i.op_a) < $signed(req_i.op_b)};
      i2_pkg::ALU_SLTU: alu_result = {{(i2_pkg::XLEN-1){1'b0}}, req_i.op_a < req_i.op_b};
      default:          alu_result = sum;
    endcase
  end

  // EX forwarding, held item keeps forwarding while stalled
  assign fwd.ex_we    = req_valid_i && req_i.we;
  assign fwd.ex_waddr = req_i.rd;
  assign fwd.ex_wdata = alu_result;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // Bubble on stall, nothing from EX on kill
  assign ex_go = req_valid_i && req_i.we && pi_ready_i && !pi_kill_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= ex_go;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_go) begin
      wb_waddr_q <= req_i.rd;
      wb_wdata_q <= alu_result;
    end
  end

  // WB entry is both the write port and a forwarding source
  assign fwd.wb_we    = wb_we_q;
  assign fwd.wb_waddr = wb_waddr_q;
  assign fwd.wb_wdata = wb_wdata_q;
  assign rf_we_o      = wb_we_q;
  assign rf_waddr_o   = wb_waddr_q;
  assign rf_wdata_o   = wb_wdata_q;

endmodule

// ==== hdl/i2_issue_lane.sv ====
// Top of the second issue lane, connects the prefetch buffer, shared register file and primary lane
`timescale 1ns/10ps

module i2_issue_lane (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Prefetch buffer
  input  logic                          pfb_valid_i,
  input  logic [31:0]                   pfb_instr_i,
  input  logic [i2_pkg::XLEN-1:0]       pfb_pc_i,
  output logic                          pfb_pop_o,
  // Primary lane control
  input  logic                          pi_ready_i,  // Low stalls both lanes
  input  logic                          pi_kill_i,   // Branch taken in primary
  // Primary cross-forward
  input  logic                          xfw_we_i,
  input  logic [i2_pkg::REG_ADDR_W-1:0] xfw_waddr_i,
  input  logic [i2_pkg::XLEN-1:0]       xfw_wdata_i,
  // Shared register file
  output logic [i2_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [i2_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [i2_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [i2_pkg::XLEN-1:0]       rf_rdata_b_i,
  output logic                          rf_we_o,
  output logic [i2_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [i2_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                          unsupported_o // Word left to the primary lane
);

  i2_pkg::fetch_t                       fetch_in;
  i2_pkg::fetch_t                       fetch_id;
  logic                                 id_valid;
  logic [1:0][i2_pkg::REG_ADDR_W-1:0]   rs_addr;
  i2_pkg::alu_op_e                      alu_op;
  logic [i2_pkg::REG_ADDR_W-1:0]        rd;
  logic                                 we;
  logic [i2_pkg::XLEN-1:0]              imm;
  logic                                 use_imm;
  logic                                 issue_valid;
  logic [1:0][i2_pkg::XLEN-1:0]         rf_rdata;
  logic [1:0][i2_pkg::XLEN-1:0]         operand;
  i2_pkg::ex_req_t                      req_id;
  i2_pkg::ex_req_t                      req_ex;
  logic                                 ex_valid;

  i2_bypass_if fwd_if ();

  //////////////////////////////
  // IF/ID
  //////////////////////////////

  assign fetch_in = '{instr: pfb_instr_i, pc: pfb_pc_i};

  i2_stage_reg #(.payload_t(i2_pkg::fetch_t)) if_id_reg (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (pfb_valid_i),
    .data_i    (fetch_in),
    .advance_i (pi_ready_i),
    .kill_i    (pi_kill_i),
    .taken_o   (pfb_pop_o),                  // Pop equals accept
    .valid_o   (id_valid),
    .data_o    (fetch_id)
  );

  //////////////////////////////
  // ID
  //////////////////////////////

  i2_decoder decoder_i (
    .valid_i       (id_valid),
    .fetch_i       (fetch_id),
    .rs_addr_o     (rs_addr),
    .alu_op_o      (alu_op),
    .rd_o          (rd),
    .we_o          (we),
    .imm_o         (imm),
    .use_imm_o     (use_imm),
    .issue_valid_o (issue_valid),
    .unsupported_o (unsupported_o)
  );

  assign rf_raddr_a_o = rs_addr[0];
  assign rf_raddr_b_o = rs_addr[1];
  assign rf_rdata[0]  = rf_rdata_a_i;
  assign rf_rdata[1]  = rf_rdata_b_i;

  // Primary cross-forward straight onto the bus
  assign fwd_if.xfw_we    = xfw_we_i;
  assign fwd_if.xfw_waddr = xfw_waddr_i;
  assign fwd_if.xfw_wdata = xfw_wdata_i;

  for (genvar g = 0; g < 2; g++) begin : g_bypass
    i2_operand_bypass bypass_i (
      .rs_addr_i  (rs_addr[g]),
      .rf_rdata_i (rf_rdata[g]),
      .fwd        (fwd_if.sink),
      .operand_o  (operand[g]),
      .src_o      ()
    );
  end

  // Operand B replaced by the immediate for OP-IMM
  assign req_id = '{alu_op: alu_op,
                    op_a:   operand[0],
                    op_b:   use_imm ? imm : operand[1],
                    rd:     rd,
                    we:     we};

  //////////////////////////////
  // ID/EX and EX
  //////////////////////////////

  i2_stage_reg #(.payload_t(i2_pkg::ex_req_t)) id_ex_reg (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (issue_valid),
    .data_i    (req_id),
    .advance_i (pi_ready_i),
    .kill_i    (pi_kill_i),
    .taken_o   (),
    .valid_o   (ex_valid),
    .data_o    (req_ex)
  );

  i2_ex_stage ex_stage_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (ex_valid),
    .req_i       (req_ex),
    .pi_ready_i  (pi_ready_i),
    .pi_kill_i   (pi_kill_i),
    .fwd         (fwd_if.ex_src),
    .rf_we_o     (rf_we_o),
    .rf_waddr_o  (rf_waddr_o),
    .rf_wdata_o  (rf_wdata_o)
  );

endmodule

// ==== verification/i2_issue_lane_assertions.sv ====
// Protocol checks on the second issue lane, bound into every i2_issue_lane instance
`timescale 1ns/10ps

module i2_issue_lane_assertions (
  input logic                                clk_i,
  input logic                                rst_i,
  input logic                                pfb_valid_i,
  input logic                                pfb_pop_o,
  input logic                                pi_ready_i,
  input logic                                pi_kill_i,
  input logic                                rf_we_o,
  input logic [i2_pkg::REG_ADDR_W-1:0]       rf_waddr_o,
  input logic                                unsupported_o
);

  // Pop only takes an offered word
  pop_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    pfb_pop_o |-> pfb_valid_i) else $error("Buffer pop without a valid word");

  // Stalled or flushed front end takes nothing
  pop_blocked: assert property (@(posedge clk_i) disable iff (rst_i)
    pfb_pop_o |-> pi_ready_i && !pi_kill_i) else $error("Buffer pop during stall or kill");

  // x0 stays hardwired
  no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
    rf_we_o |-> rf_waddr_o != '0) else $error("Register-file write to x0");

  // Outputs quiet once reset has been seen for a cycle
  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !pfb_pop_o && !rf_we_o && !unsupported_o)
    else $error("Output active during reset");

endmodule

bind i2_issue_lane i2_issue_lane_assertions assertions_i (.*);

// ==== verification/i2_issue_lane_tb.sv ====
// Directed testbench of the second issue lane with a register-file model and an in-order golden model
`timescale 1ns/10ps

module i2_issue_lane_tb;

  localparam int max_cycles = 4000; // Roughly three times the length of all tests
  // funct3 per operation, order ADD SUB AND OR XOR SLL SRL SRA SLT SLTU
  localparam logic [2:0] funct3_tbl [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4,
                                             3'd1, 3'd5, 3'd5, 3'd2, 3'd3};

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        pfb_valid_i;
  logic [31:0] pfb_instr_i;
  logic [31:0] pfb_pc_i;
  logic        pfb_pop_o;
  logic        pi_ready_i;
  logic        pi_kill_i;
  logic        xfw_we_i;
  logic [4:0]  xfw_waddr_i;
  logic [31:0] xfw_wdata_i;
  logic [4:0]  rf_raddr_a_o;
  logic [4:0]  rf_raddr_b_o;
  logic [31:0] rf_rdata_a_i;
  logic [31:0] rf_rdata_b_i;
  logic        rf_we_o;
  logic [4:0]  rf_waddr_o;
  logic [31:0] rf_wdata_o;
  logic        unsupported_o;

  logic [31:0] rf_model [32];         // Shared register file
  logic [31:0] rf_init [32];          // Loaded into rf_model during reset
  logic [31:0] gold [32];             // Architectural state in program order
  logic [4:0]  exp_rd [$];            // Expected writes, in order
  logic [31:0] exp_val [$];
  int          exp_cyc [$];           // Pop edge of each expected write
  int          seed = 32'hb6981649;
  int          cyc = 0;
  int          wr_count = 0;          // Writes seen by the monitor
  int          checks = 0;
  int          errors = 0;            // Counted by the test tasks
  int          mon_errors = 0;        // Counted by the monitor
  int          test_start;
  bit          stall_mode = 1'b0;
  bit          ready_q = 1'b0;        // pi_ready_i at the last edge
  bit          id_busy = 1'b0;        // IF/ID occupancy per the handshake rules
  logic [31:0] id_word;
  logic        exp_unsup;             // Expected unsupported_o from the IF/ID model
  logic [31:0] pc_next = 32'h0;
  string       cur_test = "reset";

  i2_issue_lane dut_i (.*);

  always #10 clk_i = ~clk_i;

  assign rf_rdata_a_i = rf_model[rf_raddr_a_o]; // Combinational reads
  assign rf_rdata_b_i = rf_model[rf_raddr_b_o];

  // Only OP and OP-IMM words are issued
  assign exp_unsup = id_busy && id_word[6:0] != 7'h33 && id_word[6:0] != 7'h13;

  //////////////////////////////
  // Models updated at the rising edge
  //////////////////////////////

  always @(posedge clk_i) begin
    cyc     <= cyc + 1;
    ready_q <= pi_ready_i;
    if (rst_i || pi_kill_i) begin
      id_busy <= 1'b0;                       // Kill empties IF/ID
    end else if (pi_ready_i) begin
      id_busy <= pfb_valid_i;
      id_word <= pfb_instr_i;
    end
    if (rst_i) begin
      rf_model <= rf_init;
    end else if (rf_we_o) begin
      rf_model[rf_waddr_o] <= rf_wdata_o;
    end
  end

  //////////////////////////////
  // Output monitor, falling edge
  //////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_i) begin
      assert (unsupported_o == exp_unsup) else begin
        mon_errors++;
        $display("[FAIL] %s: unsupported_o expected %0b actual %0b",
                 cur_test, exp_unsup, unsupported_o);
      end
      if (rf_we_o) begin
        checks++;
        assert (wr_count < exp_rd.size() && ready_q) else begin
          mon_errors++;
          $display("%s: register write with nothing pending or after a stalled edge", cur_test);
        end
        if (wr_count < exp_rd.size()) begin
          assert (rf_waddr_o == exp_rd[wr_count] && rf_wdata_o == exp_val[wr_count]) else begin
            mon_errors++;
            $display("[FAIL] %s: expected x%0d=%h actual x%0d=%h", cur_test,
                     exp_rd[wr_count], exp_val[wr_count], rf_waddr_o, rf_wdata_o);
          end
          // Two edges from pop to WB when never stalled
          assert (stall_mode || cyc == exp_cyc[wr_count] + 2) else begin
            mon_errors++;
            $display("[FAIL] %s: write cycle expected %0d actual %0d", cur_test,
                     exp_cyc[wr_count] + 2, cyc);
          end
          wr_count++;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (cyc >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Golden model and drivers
  //////////////////////////////

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // RV32I semantics of the ten operations
  function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      0:       return a + b;
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return a << b[4:0];
      6:       return a >> b[4:0];
      7:       return $signed(a) >>> b[4:0];
      8:       return {31'd0, $signed(a) < $signed(b)};
      default: return {31'd0, a < b};
    endcase
  endfunction

  // Offers a word until the lane pops it, random stalls in stall mode
  task automatic pop_word(input logic [31:0] word, output int pop_cyc);
    bit popped;
    popped = 1'b0;
    while (!popped) begin
      @(negedge clk_i);
      pfb_valid_i = 1'b1;
      pfb_instr_i = word;
      pfb_pc_i    = pc_next;
      pi_ready_i  = !(stall_mode && ($random(seed) % 2 == 0));
      pop_cyc     = cyc + 1;
      @(posedge clk_i);
      popped = pfb_pop_o;
      assert (pi_ready_i || !popped) else begin
        errors++;
        $display("%s: word popped while the primary lane stalls", cur_test);
      end
    end
    pc_next = pc_next + 32'd4;
  endtask

  // Encodes one ALU instruction, issues it and records its result unless it gets killed
  task automatic send_op(input int op, input bit use_imm, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [11:0] imm, input bit doomed);
    logic [6:0]  f7;
    logic [31:0] word;
    logic [31:0] b;
    int          pop_cyc;
    f7 = (op == 1 || op == 7) ? 7'h20 : 7'h00;  // SUB and SRA
    if (op == 5 || op == 6 || op == 7) begin
      imm = {f7, imm[4:0]};                      // Shift amount form
    end
    if (use_imm && op != 1) begin
      word = {imm, rs1, funct3_tbl[op], rd, 7'h13};
      b    = {{20{imm[11]}}, imm};
    end else begin
      word = {f7, rs2, rs1, funct3_tbl[op], rd, 7'h33};
      b    = gold[rs2];
    end
    pop_word(word, pop_cyc);
    if (!doomed && rd != 5'd0) begin
      gold[rd] = alu_model(op, gold[rs1], b);
      exp_rd.push_back(rd);
      exp_val.push_back(gold[rd]);
      exp_cyc.push_back(pop_cyc);
    end
  endtask

  // Random operation over registers below span
  task automatic send_rand(input int span, input bit doomed);
    logic [31:0] r;
    r = rand_word();
    send_op(r % 10, r[4], 5'(r[9:5] % span), 5'(r[14:10] % span), 5'(r[19:15] % span),
            r[31:20], doomed);
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    test_start = errors + mon_errors;
  endtask

  // Waits for all pending writes, then compares the whole register file
  task automatic end_test();
    @(negedge clk_i);
    pfb_valid_i = 1'b0;
    pi_ready_i  = 1'b1;
    while (wr_count != exp_rd.size()) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    for (int i = 0; i < 32; i++) begin
      assert (rf_model[i] == gold[i]) else begin
        errors++;
        $display("[FAIL] %s: x%0d expected %h actual %h", cur_test, i, gold[i], rf_model[i]);
      end
    end
    $display("test %-12s done, %0d errors", cur_test, errors + mon_errors - test_start);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_each_op();
    logic [31:0] r;
    start_test("each_op");
    for (int op = 0; op < 10; op++) begin
      r = rand_word();
      send_op(op, 1'b0, 5'(10 + op), 5'd1, 5'd2, 12'h0, 1'b0);     // Sources never written
      send_op(op, 1'b1, 5'(20 + op), 5'd3, 5'd0, r[11:0], 1'b0);
    end
    end_test();
  endtask

  task automatic test_dependent();
    start_test("dependent");
    repeat (400) send_rand(8, 1'b0);         // x0..x7 only, dense hazards
    end_test();
  endtask

  task automatic test_cross_forward();
    logic [31:0] stale;
    logic [31:0] fresh;
    start_test("cross_fwd");
    stale   = gold[5];
    fresh   = rand_word();
    gold[5] = fresh;                         // Primary value seen through the forward
    send_op(0, 1'b0, 5'd6, 5'd5, 5'd7, 12'h0, 1'b0);
    gold[5] = stale;                         // Never written into our register file
    @(negedge clk_i);
    pfb_valid_i = 1'b0;
    xfw_we_i    = 1'b1;
    xfw_waddr_i = 5'd5;
    xfw_wdata_i = fresh;
    @(negedge clk_i);
    xfw_we_i = 1'b0;
    // Own EX result for x8 beats the primary forward
    send_op(0, 1'b0, 5'd8, 5'd1, 5'd2, 12'h0, 1'b0);
    send_op(4, 1'b0, 5'd9, 5'd8, 5'd3, 12'h0, 1'b0);
    @(negedge clk_i);
    pfb_valid_i = 1'b0;
    xfw_we_i    = 1'b1;
    xfw_waddr_i = 5'd8;
    xfw_wdata_i = ~gold[8];
    @(negedge clk_i);
    xfw_we_i = 1'b0;
    end_test();
  endtask

  task automatic test_stall();
    start_test("stall");
    stall_mode = 1'b1;
    repeat (400) send_rand(8, 1'b0);
    end_test();
    stall_mode = 1'b0;                       // Late writes are still in flight until here
  endtask

  task automatic test_kill();
    start_test("kill");
    send_op(0, 1'b0, 5'd10, 5'd1, 5'd2, 12'h0, 1'b0);    // In WB at the kill edge
    send_op(3, 1'b0, 5'd11, 5'd10, 5'd2, 12'h0, 1'b1);   // In ID/EX, dropped
    send_op(4, 1'b1, 5'd12, 5'd10, 5'd0, 12'h5a5, 1'b1); // In IF/ID, dropped
    @(negedge clk_i);
    pi_kill_i = 1'b1;                        // Buffer still offers a word
    @(posedge clk_i);
    assert (!pfb_pop_o) else begin
      errors++;
      $display("%s: word popped at the kill edge", cur_test);
    end
    @(negedge clk_i);
    pi_kill_i   = 1'b0;
    pfb_valid_i = 1'b0;
    send_op(0, 1'b0, 5'd13, 5'd11, 5'd12, 12'h0, 1'b0);  // Must see the old x11 and x12
    end_test();
  endtask

  task automatic test_unsupported();
    int pop_cyc;
    start_test("unsupported");
    send_op(0, 1'b0, 5'd14, 5'd1, 5'd2, 12'h0, 1'b0);
    pop_word({12'h010, 5'd14, 3'b010, 5'd15, 7'h03}, pop_cyc);  // LW x15, 16(x14)
    send_op(0, 1'b0, 5'd16, 5'd14, 5'd15, 12'h0, 1'b0);
    end_test();
  endtask

  initial begin
    rst_i       = 1'b1;
    pfb_valid_i = 1'b0;
    pfb_instr_i = 32'h0;
    pfb_pc_i    = 32'h0;
    pi_ready_i  = 1'b1;
    pi_kill_i   = 1'b0;
    xfw_we_i    = 1'b0;
    xfw_waddr_i = 5'd0;
    xfw_wdata_i = 32'h0;
    for (int i = 0; i < 32; i++) begin
      rf_init[i] = (i == 0) ? 32'h0 : rand_word();
      gold[i]    = rf_init[i];
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_each_op();
    test_dependent();
    test_cross_forward();
    test_stall();
    test_kill();
    test_unsupported();
    $display("%0d writes checked, %0d errors", checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hdl/i2_pkg.sv
hdl/i2_bypass_if.sv
hdl/i2_stage_reg.sv
hdl/i2_decoder.sv
hdl/i2_operand_bypass.sv
hdl/i2_ex_stage.sv
hdl/i2_issue_lane.sv
verification/i2_issue_lane_assertions.sv
verification/i2_issue_lane_tb.sv

// ==== Makefile ====
TOP := i2_issue_lane_tb
RTL := hdl/i2_pkg.sv hdl/i2_bypass_if.sv hdl/i2_stage_reg.sv hdl/i2_decoder.sv \
       hdl/i2_operand_bypass.sv hdl/i2_ex_stage.sv hdl/i2_issue_lane.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only $(RTL) --top-module i2_issue_lane
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f $(RTL) verification/i2_issue_lane_tb.sv \
                 verification/i2_issue_lane_assertions.sv
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir
